// ==== all.f ====
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_way_ram.sv
verilog/dcache_tag_store.sv
verilog/dcache_data_path.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
sim/dcache_mem_model.sv
sim/dcache_tb.sv

// ==== sim/dcache_mem_model.sv ====
// memory bus responder for the cache testbench
// word array preset to an address pattern, random ready delays
// counts line writebacks
`timescale 1ns/10ps

module dcache_mem_model (
  input  logic              clk,
  input  logic              rst,
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  input  dcache_pkg::addr_t ar_addr_i,
  output logic              r_valid_o,
  input  logic              r_ready_i,
  output dcache_pkg::word_t r_data_o,
  input  logic              aw_valid_i,
  output logic              aw_ready_o,
  input  dcache_pkg::addr_t aw_addr_i,
  input  logic              w_valid_i,
  output logic              w_ready_o,
  input  dcache_pkg::word_t w_data_i,
  output logic              b_valid_o,
  input  logic              b_ready_i,
  output int                wb_count_o
);

  localparam int MEM_WORDS = 512;   // 4 KiB of address space

  dcache_pkg::word_t mem [MEM_WORDS];
  dcache_pkg::addr_t rd_addr = '0;
  dcache_pkg::addr_t wr_addr = '0;
  dcache_pkg::word_t r_dat   = '0;
  int                rd_left = 0;
  int                wr_left = 0;
  int                wb_cnt  = 0;
  logic              ar_rdy  = 1'b0;
  logic              aw_rdy  = 1'b0;
  logic              w_rdy   = 1'b0;
  logic              r_vld   = 1'b0;
  logic              b_vld   = 1'b0;

  assign ar_ready_o = ar_rdy;
  assign aw_ready_o = aw_rdy;
  assign w_ready_o  = w_rdy;
  assign r_valid_o  = r_vld;
  assign r_data_o   = r_dat;
  assign b_valid_o  = b_vld;
  assign wb_count_o = wb_cnt;

  function automatic dcache_pkg::word_t pattern_word(input dcache_pkg::addr_t addr);
    return {addr ^ 32'h3c5a_96e1, ~addr};
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= pattern_word(dcache_pkg::addr_t'(i * 8));
      end
      ar_rdy  <= 1'b0;
      aw_rdy  <= 1'b0;
      w_rdy   <= 1'b0;
      r_vld   <= 1'b0;
      b_vld   <= 1'b0;
      rd_left <= 0;
      wr_left <= 0;
      wb_cnt  <= 0;
    end else begin
      ar_rdy <= ($urandom % 3 == 0);
      aw_rdy <= ($urandom % 3 == 0);
      // refill: two beats, lower word first
      if (ar_valid_i && ar_rdy) begin
        rd_addr <= ar_addr_i;
        rd_left <= 2;
      end
      if (r_vld && r_ready_i) begin
        r_vld   <= 1'b0;
        rd_addr <= rd_addr + 32'd8;
        rd_left <= rd_left - 1;
      end else if (!r_vld && rd_left != 0 && $urandom % 2 == 0) begin
        r_vld <= 1'b1;
        r_dat <= mem[rd_addr[11:3]];
      end
      // writeback
      if (aw_valid_i && aw_rdy) begin
        wr_addr <= aw_addr_i;
        wr_left <= 2;
      end
      if (w_valid_i && w_rdy) begin
        mem[wr_addr[11:3]] <= w_data_i;
        wr_addr <= wr_addr + 32'd8;
        wr_left <= wr_left - 1;
        w_rdy   <= 1'b0;
        if (wr_left == 1) begin
          b_vld  <= 1'b1;        // response after last beat
          wb_cnt <= wb_cnt + 1;
        end
      end else begin
        w_rdy <= (wr_left != 0) && ($urandom % 2 == 0);
      end
      if (b_vld && b_ready_i) b_vld <= 1'b0;
    end
  end

endmodule

// ==== sim/dcache_tb.sv ====
// testbench for the two-way data cache
// random reads and strobed writes over few indexes, shadow memory
// assertions on read data, writeback data, hit timing and channel stability
`timescale 1ns/10ps

module dcache_tb;

  localparam int TIMEOUT   = 200;
  localparam int NUM_OPS   = 400;
  localparam int MEM_WORDS = 512;

  logic              clk      = 1'b0;
  logic              rst      = 1'b1;
  logic              ar_valid = 1'b0;
  dcache_pkg::addr_t ar_addr  = '0;
  logic              r_ready  = 1'b0;
  logic              aw_valid = 1'b0;
  dcache_pkg::addr_t aw_addr  = '0;
  logic              w_valid  = 1'b0;
  dcache_pkg::strb_t w_strb   = '0;
  dcache_pkg::word_t w_data   = '0;
  logic              b_ready  = 1'b0;
  logic              ar_ready;
  logic              r_valid;
  logic              aw_ready;
  logic              w_ready;
  logic              b_valid;
  dcache_pkg::word_t r_data;
  logic              mem_ar_valid;
  logic              mem_ar_ready;
  logic              mem_r_valid;
  logic              mem_r_ready;
  logic              mem_aw_valid;
  logic              mem_aw_ready;
  logic              mem_w_valid;
  logic              mem_w_ready;
  logic              mem_b_valid;
  logic              mem_b_ready;
  dcache_pkg::addr_t mem_ar_addr;
  dcache_pkg::addr_t mem_aw_addr;
  dcache_pkg::word_t mem_r_data;
  dcache_pkg::word_t mem_w_data;
  int                wb_count;

  dcache_pkg::word_t shadow [MEM_WORDS];   // byte-exact view of memory
  dcache_pkg::addr_t rd_addr_q;
  dcache_pkg::addr_t wr_addr_q;
  dcache_pkg::addr_t wb_addr_q;
  logic [27:0]       last_line;
  logic              last_was_read;
  logic              fast_due;
  logic              wb_beat;

  dcache_top i_dut (
    .clk            (clk),            .rst            (rst),
    .ar_valid_i     (ar_valid),       .ar_ready_o     (ar_ready),
    .ar_addr_i      (ar_addr),        .r_valid_o      (r_valid),
    .r_ready_i      (r_ready),        .r_data_o       (r_data),
    .aw_valid_i     (aw_valid),       .aw_ready_o     (aw_ready),
    .aw_addr_i      (aw_addr),        .w_valid_i      (w_valid),
    .w_ready_o      (w_ready),        .w_strb_i       (w_strb),
    .w_data_i       (w_data),         .b_valid_o      (b_valid),
    .b_ready_i      (b_ready),        .mem_ar_valid_o (mem_ar_valid),
    .mem_ar_ready_i (mem_ar_ready),   .mem_ar_addr_o  (mem_ar_addr),
    .mem_r_valid_i  (mem_r_valid),    .mem_r_ready_o  (mem_r_ready),
    .mem_r_data_i   (mem_r_data),     .mem_aw_valid_o (mem_aw_valid),
    .mem_aw_ready_i (mem_aw_ready),   .mem_aw_addr_o  (mem_aw_addr),
    .mem_w_valid_o  (mem_w_valid),    .mem_w_ready_i  (mem_w_ready),
    .mem_w_data_o   (mem_w_data),     .mem_b_valid_i  (mem_b_valid),
    .mem_b_ready_o  (mem_b_ready)
  );

  dcache_mem_model i_mem (
    .clk        (clk),          .rst        (rst),
    .ar_valid_i (mem_ar_valid), .ar_ready_o (mem_ar_ready),
    .ar_addr_i  (mem_ar_addr),  .r_valid_o  (mem_r_valid),
    .r_ready_i  (mem_r_ready),  .r_data_o   (mem_r_data),
    .aw_valid_i (mem_aw_valid), .aw_ready_o (mem_aw_ready),
    .aw_addr_i  (mem_aw_addr),  .w_valid_i  (mem_w_valid),
    .w_ready_o  (mem_w_ready),  .w_data_i   (mem_w_data),
    .b_valid_o  (mem_b_valid),  .b_ready_i  (mem_b_ready),
    .wb_count_o (wb_count)
  );

  always #10 clk = ~clk;

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] want);
    abort_run($sformatf("Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, want));
  endtask

  function automatic dcache_pkg::word_t pattern_word(input dcache_pkg::addr_t addr);
    return {addr ^ 32'h3c5a_96e1, ~addr};
  endfunction

  // four tags over two indexes, so lines keep getting evicted
  function automatic dcache_pkg::addr_t random_addr();
    logic [21:0] tag;
    logic [5:0]  index;
    tag   = 22'($urandom % 4);
    index = ($urandom % 2 == 0) ? 6'd5 : 6'd37;
    return {tag, index, 1'($urandom % 2), 3'b000};
  endfunction

  task automatic read_word(input dcache_pkg::addr_t addr);
    int   t;
    logic done;
    ar_valid <= 1'b1;
    ar_addr  <= addr;
    t = 0;
    do begin
      @(posedge clk);
      t++;
      if (t > TIMEOUT) abort_run("timeout: ar_ready_o never rose for a read");
    end while (!ar_ready);
    ar_valid <= 1'b0;
    r_ready  <= ($urandom % 2 == 0);
    t = 0;
    do begin
      @(posedge clk);
      t++;
      if (t > TIMEOUT) abort_run("timeout: read data never transferred");
      done = r_valid && r_ready;
      if (!done) r_ready <= ($urandom % 2 == 0);
    end while (!done);
    r_ready <= 1'b0;
  endtask

  task automatic store_bytes(input dcache_pkg::addr_t addr, input dcache_pkg::strb_t strb,
                             input dcache_pkg::word_t data);
    int   t;
    logic done;
    aw_valid <= 1'b1;
    aw_addr  <= addr;
    t = 0;
    do begin
      @(posedge clk);
      t++;
      if (t > TIMEOUT) abort_run("timeout: aw_ready_o never rose for a write");
    end while (!aw_ready);
    aw_valid <= 1'b0;
    w_valid  <= 1'b1;
    w_strb   <= strb;
    w_data   <= data;
    t = 0;
    do begin
      @(posedge clk);
      t++;
      if (t > TIMEOUT) abort_run("timeout: w_ready_o never rose for a write");
    end while (!w_ready);
    w_valid <= 1'b0;
    b_ready <= ($urandom % 2 == 0);
    t = 0;
    do begin
      @(posedge clk);
      t++;
      if (t > TIMEOUT) abort_run("timeout: write response never transferred");
      done = b_valid && b_ready;
      if (!done) b_ready <= ($urandom % 2 == 0);
    end while (!done);
    b_ready <= 1'b0;
  endtask

  // shadow memory and value checks at handshakes
  always @(posedge clk) begin
    dcache_pkg::word_t expected;
    if (rst) begin
      for (int i = 0; i < MEM_WORDS; i++) shadow[i] = pattern_word(dcache_pkg::addr_t'(i * 8));
      last_was_read <= 1'b0;
      fast_due      <= 1'b0;
      wb_beat       <= 1'b0;
    end else begin
      if (fast_due) begin
        assert (r_valid) else abort_run("r_valid_o not high one cycle after a repeated read");
      end
      fast_due <= ar_valid && ar_ready && last_was_read && (ar_addr[31:4] == last_line);
      if (ar_valid && ar_ready) rd_addr_q <= ar_addr;
      if (aw_valid && aw_ready) begin
        wr_addr_q     <= aw_addr;
        last_was_read <= 1'b0;
      end
      if (r_valid && r_ready) begin
        expected = shadow[rd_addr_q[11:3]];
        assert (r_data == expected) else report_mismatch("r_data_o", r_data, expected);
        last_was_read <= 1'b1;
        last_line     <= rd_addr_q[31:4];
      end
      if (w_valid && w_ready) begin
        for (int b = 0; b < 8; b++) begin
          if (w_strb[b]) shadow[wr_addr_q[11:3]][b*8 +: 8] = w_data[b*8 +: 8];
        end
      end
      if (mem_aw_valid && mem_aw_ready) begin
        assert (mem_aw_addr[3:0] == 4'h0)
          else report_mismatch("mem_aw_addr_o[3:0]", 64'(mem_aw_addr[3:0]), 64'h0);
        wb_addr_q <= mem_aw_addr;
        wb_beat   <= 1'b0;
      end
      if (mem_w_valid && mem_w_ready) begin
        expected = shadow[{wb_addr_q[11:4], wb_beat}];
        assert (mem_w_data == expected) else report_mismatch("mem_w_data_o", mem_w_data, expected);
        wb_beat <= ~wb_beat;
      end
      if (mem_ar_valid && mem_ar_ready) begin
        assert (mem_ar_addr[3:0] == 4'h0)
          else report_mismatch("mem_ar_addr_o[3:0]", 64'(mem_ar_addr[3:0]), 64'h0);
      end
    end
  end

  a_r_hold: assert property (@(posedge clk) disable iff (rst)
    r_valid && !r_ready |=> r_valid && $stable(r_data))
    else abort_run("r_valid_o dropped or r_data_o changed while r_ready_i was low");
  a_b_hold: assert property (@(posedge clk) disable iff (rst)
    b_valid && !b_ready |=> b_valid)
    else abort_run("b_valid_o dropped while b_ready_i was low");
  a_mem_ar_hold: assert property (@(posedge clk) disable iff (rst)
    mem_ar_valid && !mem_ar_ready |=> mem_ar_valid && $stable(mem_ar_addr))
    else abort_run("mem_ar_valid_o dropped or mem_ar_addr_o changed before its ready");
  a_mem_aw_hold: assert property (@(posedge clk) disable iff (rst)
    mem_aw_valid && !mem_aw_ready |=> mem_aw_valid && $stable(mem_aw_addr))
    else abort_run("mem_aw_valid_o dropped or mem_aw_addr_o changed before its ready");
  a_mem_w_hold: assert property (@(posedge clk) disable iff (rst)
    mem_w_valid && !mem_w_ready |=> mem_w_valid && $stable(mem_w_data))
    else abort_run("mem_w_valid_o dropped or mem_w_data_o changed before its ready");

  initial begin
    int unsigned       seed;
    dcache_pkg::addr_t addr;
    seed = $urandom(77);
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    // first cycle out of reset
    assert ({ar_ready, aw_ready, r_valid, w_ready, b_valid, mem_ar_valid, mem_aw_valid,
             mem_w_valid, mem_r_ready, mem_b_ready} == 10'b11_0000_0000)
      else report_mismatch("{ar_ready_o .. mem_b_ready_o}",
                           64'({ar_ready, aw_ready, r_valid, w_ready, b_valid, mem_ar_valid,
                                mem_aw_valid, mem_w_valid, mem_r_ready, mem_b_ready}),
                           64'h300);
    for (int n = 0; n < NUM_OPS; n++) begin
      addr = random_addr();
      if ($urandom % 2 == 0) begin
        read_word(addr);
        if ($urandom % 3 == 0) read_word({addr[31:4], ~addr[3], 3'b000});  // same line again
      end else begin
        store_bytes(addr, 8'($urandom), {$urandom, $urandom});
      end
    end
    if (wb_count == 0) begin
      abort_run("no line writeback happened during the run");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

// ==== verilog/dcache_consts.svh ====
// geometry constants for the two-way data cache
// address split, word/line widths, set and way counts
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

`define DC_ADDR_W       32
`define DC_WORD_W       64
`define DC_LINE_W       128
`define DC_STRB_W       8
`define DC_TAG_W        22
`define DC_INDEX_W      6
`define DC_OFFSET_W     4
`define DC_SETS         64
`define DC_WAYS         2

// address layout is tag [31:10], index [9:4], offset [3:0]
`define DC_TAG_LSB      10
`define DC_INDEX_LSB    4
`define DC_WORD_SEL_BIT 3   // upper word of a line

`endif

// ==== verilog/dcache_ctrl.sv ====
// cache controller FSM
// cpu and memory channel handshakes, beat counting
// tag store updates and ram strobes
`timescale 1ns/10ps
`include "dcache_consts.svh"

module dcache_ctrl (
  input  logic               clk,
  input  logic               rst,
  input  logic               ar_valid_i,
  output logic               ar_ready_o,
  input  dcache_pkg::addr_t  ar_addr_i,
  output logic               r_valid_o,
  input  logic               r_ready_i,
  input  logic               aw_valid_i,
  output logic               aw_ready_o,
  input  dcache_pkg::addr_t  aw_addr_i,
  input  logic               w_valid_i,
  output logic               w_ready_o,
  output logic               b_valid_o,
  input  logic               b_ready_i,
  output logic               mem_ar_valid_o,
  input  logic               mem_ar_ready_i,
  output dcache_pkg::addr_t  mem_ar_addr_o,
  input  logic               mem_r_valid_i,
  output logic               mem_r_ready_o,
  output logic               mem_aw_valid_o,
  input  logic               mem_aw_ready_i,
  output dcache_pkg::addr_t  mem_aw_addr_o,
  output logic               mem_w_valid_o,
  input  logic               mem_w_ready_i,
  input  logic               mem_b_valid_i,
  output logic               mem_b_ready_o,
  output dcache_pkg::index_t lookup_index_o,
  output dcache_pkg::tag_t   lookup_tag_o,
  input  logic               hit_i,
  input  dcache_pkg::way_t   hit_way_i,
  input  dcache_pkg::way_t   victim_way_i,
  input  logic               victim_dirty_i,
  input  dcache_pkg::tag_t   victim_tag_i,
  output logic               upd_en_o,
  output dcache_pkg::way_t   upd_way_o,
  output dcache_pkg::index_t upd_index_o,
  output dcache_pkg::tag_t   upd_tag_o,
  output logic               upd_valid_o,
  output logic               set_dirty_o,
  output logic               ram_rd_o,
  output logic               ram_wr_o,
  output dcache_pkg::way_t   ram_way_o,
  output dcache_pkg::index_t ram_index_o,
  output logic               fill_o,
  output logic               beat_o,
  output logic               word_sel_o
);

  dcache_pkg::ctrl_state_t state_q;
  dcache_pkg::ctrl_state_t state_d;
  dcache_pkg::addr_t       req_addr;
  dcache_pkg::addr_t       addr_q;
  dcache_pkg::tag_t        vtag_q;
  dcache_pkg::index_t      req_index;
  dcache_pkg::index_t      addr_index;
  dcache_pkg::way_t        way_q;
  logic                    is_wr_q;
  logic                    beat_q;
  logic                    idle;
  logic                    req_fire;
  logic                    miss;
  logic                    r_fire;
  logic                    w_fire;
  logic                    b_fire;
  logic                    wb_fire;
  logic                    fill_fire;

  assign idle       = (state_q == dcache_pkg::IDLE);
  assign req_addr   = ar_valid_i ? ar_addr_i : aw_addr_i;  // read wins
  assign req_index  = req_addr[`DC_TAG_LSB-1:`DC_INDEX_LSB];
  assign addr_index = addr_q[`DC_TAG_LSB-1:`DC_INDEX_LSB];
  assign req_fire   = idle && (ar_valid_i || aw_valid_i);
  assign miss       = req_fire && !hit_i;

  assign lookup_index_o = req_index;
  assign lookup_tag_o   = req_addr[`DC_ADDR_W-1:`DC_TAG_LSB];

  // cpu channels
  assign ar_ready_o = idle;
  assign aw_ready_o = idle && !ar_valid_i;
  assign r_valid_o  = (state_q == dcache_pkg::HIT) && !is_wr_q;
  assign w_ready_o  = (state_q == dcache_pkg::HIT) && is_wr_q;
  assign b_valid_o  = (state_q == dcache_pkg::RESP);
  assign r_fire     = r_valid_o && r_ready_i;
  assign w_fire     = w_ready_o && w_valid_i;
  assign b_fire     = b_valid_o && b_ready_i;

  // memory channels
  assign mem_aw_valid_o = (state_q == dcache_pkg::WB_ADDR);
  assign mem_aw_addr_o  = {vtag_q, addr_index, {`DC_OFFSET_W{1'b0}}};
  assign mem_w_valid_o  = (state_q == dcache_pkg::WB_DATA);
  assign mem_b_ready_o  = (state_q == dcache_pkg::WB_RESP);
  assign mem_ar_valid_o = (state_q == dcache_pkg::FILL_ADDR);
  assign mem_ar_addr_o  = {addr_q[`DC_ADDR_W-1:`DC_INDEX_LSB], {`DC_OFFSET_W{1'b0}}};
  assign mem_r_ready_o  = (state_q == dcache_pkg::FILL_DATA);
  assign wb_fire        = mem_w_valid_o && mem_w_ready_i;
  assign fill_fire      = mem_r_ready_o && mem_r_valid_i;

  // tag updates invalidate the victim, set the new tag, validate after last beat
  assign upd_en_o    = miss || (state_q == dcache_pkg::FILL_ADDR) || (fill_fire && beat_q);
  assign upd_way_o   = idle ? victim_way_i : way_q;
  assign upd_index_o = idle ? req_index : addr_index;
  assign upd_tag_o   = idle ? victim_tag_i : addr_q[`DC_ADDR_W-1:`DC_TAG_LSB];
  assign upd_valid_o = (state_q == dcache_pkg::FILL_DATA);
  assign set_dirty_o = w_fire;

  assign ram_rd_o    = (req_fire && hit_i) || (state_q == dcache_pkg::WB_ADDR)
                       || (state_q == dcache_pkg::REREAD);
  assign ram_wr_o    = w_fire || fill_fire;
  assign ram_way_o   = way_q;
  assign ram_index_o = idle ? req_index : addr_index;
  assign fill_o      = (state_q == dcache_pkg::FILL_DATA);
  assign beat_o      = beat_q;
  assign word_sel_o  = addr_q[`DC_WORD_SEL_BIT];

  always_comb begin
    state_d = state_q;
    case (state_q)
      dcache_pkg::IDLE: begin
        if (req_fire) begin
          if (hit_i) state_d = dcache_pkg::HIT;
          else if (victim_dirty_i) state_d = dcache_pkg::WB_ADDR;
          else state_d = dcache_pkg::FILL_ADDR;
        end
      end
      dcache_pkg::HIT: begin
        if (w_fire) state_d = dcache_pkg::RESP;
        else if (r_fire) state_d = dcache_pkg::IDLE;
      end
      dcache_pkg::RESP:      if (b_fire) state_d = dcache_pkg::IDLE;
      dcache_pkg::WB_ADDR:   if (mem_aw_ready_i) state_d = dcache_pkg::WB_DATA;
      dcache_pkg::WB_DATA:   if (wb_fire && beat_q) state_d = dcache_pkg::WB_RESP;
      dcache_pkg::WB_RESP:   if (mem_b_valid_i) state_d = dcache_pkg::FILL_ADDR;
      dcache_pkg::FILL_ADDR: if (mem_ar_ready_i) state_d = dcache_pkg::FILL_DATA;
      dcache_pkg::FILL_DATA: if (fill_fire && beat_q) state_d = dcache_pkg::REREAD;
      dcache_pkg::REREAD:    state_d = dcache_pkg::HIT;
      default:               state_d = dcache_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= dcache_pkg::IDLE;
      beat_q  <= 1'b0;
      is_wr_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (wb_fire || fill_fire) beat_q <= ~beat_q;  // wraps after 2nd beat
      if (req_fire) is_wr_q <= !ar_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      addr_q <= req_addr;
      way_q  <= hit_i ? hit_way_i : victim_way_i;
      vtag_q <= victim_tag_i;
    end
  end

  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    mem_ar_valid_o && !mem_ar_ready_i |=> mem_ar_valid_o);
  a_aw_hold: assert property (@(posedge clk) disable iff (rst)
    mem_aw_valid_o && !mem_aw_ready_i |=> mem_aw_valid_o);

endmodule

// ==== verilog/dcache_data_path.sv ====
// data side of the cache
// two way rams, write data and mask placement
// word select for cpu reads and writeback beats
`timescale 1ns/10ps
`include "dcache_consts.svh"

module dcache_data_path (
  input  logic               clk,
  input  logic               rd_en_i,
  input  logic               wr_en_i,
  input  dcache_pkg::way_t   way_i,
  input  dcache_pkg::index_t index_i,
  input  logic               fill_i,
  input  logic               beat_i,
  input  logic               word_sel_i,
  input  dcache_pkg::strb_t  w_strb_i,
  input  dcache_pkg::word_t  w_data_i,
  input  dcache_pkg::word_t  mem_r_data_i,
  output dcache_pkg::word_t  rd_word_o,
  output dcache_pkg::word_t  wb_word_o
);

  dcache_pkg::word_t half_mask;
  dcache_pkg::word_t wr_word;
  dcache_pkg::line_t wmask;
  dcache_pkg::line_t wdata;
  dcache_pkg::line_t way_line;
  dcache_pkg::line_t rdata [`DC_WAYS];
  logic              upper;

  // refill beats write whole words
  always_comb begin
    for (int b = 0; b < `DC_STRB_W; b++) begin
      half_mask[b*8 +: 8] = fill_i ? 8'hff : {8{w_strb_i[b]}};
    end
  end

  assign wr_word = fill_i ? mem_r_data_i : w_data_i;
  assign upper   = fill_i ? beat_i : word_sel_i;
  assign wdata   = {wr_word, wr_word};
  assign wmask   = upper ? {half_mask, {`DC_WORD_W{1'b0}}} : {{`DC_WORD_W{1'b0}}, half_mask};

  for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
    dcache_way_ram i_ram (
      .clk     (clk),
      .rd_en_i (rd_en_i),
      .wr_en_i (wr_en_i && (way_i == dcache_pkg::way_t'(w))),
      .index_i (index_i),
      .wmask_i (wmask),
      .wdata_i (wdata),
      .rdata_o (rdata[w])
    );
  end

  assign way_line  = rdata[way_i];
  assign rd_word_o = word_sel_i ? way_line[`DC_LINE_W-1:`DC_WORD_W] : way_line[`DC_WORD_W-1:0];
  assign wb_word_o = beat_i ? way_line[`DC_LINE_W-1:`DC_WORD_W] : way_line[`DC_WORD_W-1:0];

endmodule

// ==== verilog/dcache_pkg.sv ====
// shared cache types
// address, word, line, strobe, tag, index and way types
// controller state enumeration
`include "dcache_consts.svh"

package dcache_pkg;

  typedef logic [`DC_ADDR_W-1:0]          addr_t;
  typedef logic [`DC_WORD_W-1:0]          word_t;
  typedef logic [`DC_LINE_W-1:0]          line_t;
  typedef logic [`DC_STRB_W-1:0]          strb_t;
  typedef logic [`DC_TAG_W-1:0]           tag_t;
  typedef logic [`DC_INDEX_W-1:0]         index_t;
  typedef logic [$clog2(`DC_WAYS)-1:0]    way_t;

  typedef enum logic [3:0] {
    IDLE,
    HIT,        // line in ram, cpu data phase
    RESP,       // write response
    WB_ADDR,
    WB_DATA,
    WB_RESP,
    FILL_ADDR,
    FILL_DATA,
    REREAD      // read refilled line back
  } ctrl_state_t;

endpackage

// ==== verilog/dcache_tag_store.sv ====
// tag, valid and dirty arrays for both ways
// combinational hit lookup
// free-running victim counter with victim dirty/tag report
`timescale 1ns/10ps
`include "dcache_consts.svh"

module dcache_tag_store (
  input  logic               clk,
  input  logic               rst,
  input  dcache_pkg::index_t lookup_index_i,
  input  dcache_pkg::tag_t   lookup_tag_i,
  output logic               hit_o,
  output dcache_pkg::way_t   hit_way_o,
  output dcache_pkg::way_t   victim_way_o,
  output logic               victim_dirty_o,
  output dcache_pkg::tag_t   victim_tag_o,
  input  logic               upd_en_i,
  input  dcache_pkg::way_t   upd_way_i,
  input  dcache_pkg::index_t upd_index_i,
  input  dcache_pkg::tag_t   upd_tag_i,
  input  logic               upd_valid_i,
  input  logic               set_dirty_i
);

  dcache_pkg::tag_t                  tag_q [`DC_WAYS][`DC_SETS];
  logic [`DC_WAYS-1:0][`DC_SETS-1:0] valid_q;
  logic [`DC_WAYS-1:0][`DC_SETS-1:0] dirty_q;
  logic [`DC_WAYS-1:0]               hit_vec;
  dcache_pkg::way_t                  victim_q;

  always_comb begin
    for (int w = 0; w < `DC_WAYS; w++) begin
      hit_vec[w] = valid_q[w][lookup_index_i] && (tag_q[w][lookup_index_i] == lookup_tag_i);
    end
  end

  assign hit_o          = |hit_vec;
  assign hit_way_o      = hit_vec[1];
  assign victim_way_o   = victim_q;
  assign victim_dirty_o = dirty_q[victim_q][lookup_index_i];
  assign victim_tag_o   = tag_q[victim_q][lookup_index_i];

  always_ff @(posedge clk) begin
    if (upd_en_i) begin
      tag_q[upd_way_i][upd_index_i] <= upd_tag_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q  <= '0;
      dirty_q  <= '0;
      victim_q <= '0;
    end else begin
      victim_q <= victim_q + 1'b1;  // pseudo-random replacement
      if (upd_en_i) begin
        valid_q[upd_way_i][upd_index_i] <= upd_valid_i;
        dirty_q[upd_way_i][upd_index_i] <= 1'b0;
      end else if (set_dirty_i) begin
        dirty_q[upd_way_i][upd_index_i] <= 1'b1;
      end
    end
  end

  // a line lives in one way only, so one index never hits twice
  a_single_hit: assert property (@(posedge clk) disable iff (rst)
    !(hit_vec[0] && hit_vec[1]));

endmodule

// ==== verilog/dcache_top.sv ====
// data cache top level
// controller, tag store and data path between cpu and memory ports
`timescale 1ns/10ps

module dcache_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  input  dcache_pkg::addr_t ar_addr_i,
  output logic              r_valid_o,
  input  logic              r_ready_i,
  output dcache_pkg::word_t r_data_o,
  input  logic              aw_valid_i,
  output logic              aw_ready_o,
  input  dcache_pkg::addr_t aw_addr_i,
  input  logic              w_valid_i,
  output logic              w_ready_o,
  input  dcache_pkg::strb_t w_strb_i,
  input  dcache_pkg::word_t w_data_i,
  output logic              b_valid_o,
  input  logic              b_ready_i,
  output logic              mem_ar_valid_o,
  input  logic              mem_ar_ready_i,
  output dcache_pkg::addr_t mem_ar_addr_o,
  input  logic              mem_r_valid_i,
  output logic              mem_r_ready_o,
  input  dcache_pkg::word_t mem_r_data_i,
  output logic              mem_aw_valid_o,
  input  logic              mem_aw_ready_i,
  output dcache_pkg::addr_t mem_aw_addr_o,
  output logic              mem_w_valid_o,
  input  logic              mem_w_ready_i,
  output dcache_pkg::word_t mem_w_data_o,
  input  logic              mem_b_valid_i,
  output logic              mem_b_ready_o
);

  dcache_pkg::index_t lookup_index;
  dcache_pkg::index_t upd_index;
  dcache_pkg::index_t ram_index;
  dcache_pkg::tag_t   lookup_tag;
  dcache_pkg::tag_t   victim_tag;
  dcache_pkg::tag_t   upd_tag;
  dcache_pkg::way_t   hit_way;
  dcache_pkg::way_t   victim_way;
  dcache_pkg::way_t   upd_way;
  dcache_pkg::way_t   ram_way;
  logic               hit;
  logic               victim_dirty;
  logic               upd_en;
  logic               upd_valid;
  logic               set_dirty;
  logic               ram_rd;
  logic               ram_wr;
  logic               fill;
  logic               beat;
  logic               word_sel;

  dcache_ctrl i_ctrl (
    .clk            (clk),            .rst            (rst),
    .ar_valid_i     (ar_valid_i),     .ar_ready_o     (ar_ready_o),
    .ar_addr_i      (ar_addr_i),      .r_valid_o      (r_valid_o),
    .r_ready_i      (r_ready_i),      .aw_valid_i     (aw_valid_i),
    .aw_ready_o     (aw_ready_o),     .aw_addr_i      (aw_addr_i),
    .w_valid_i      (w_valid_i),      .w_ready_o      (w_ready_o),
    .b_valid_o      (b_valid_o),      .b_ready_i      (b_ready_i),
    .mem_ar_valid_o (mem_ar_valid_o), .mem_ar_ready_i (mem_ar_ready_i),
    .mem_ar_addr_o  (mem_ar_addr_o),  .mem_r_valid_i  (mem_r_valid_i),
    .mem_r_ready_o  (mem_r_ready_o),  .mem_aw_valid_o (mem_aw_valid_o),
    .mem_aw_ready_i (mem_aw_ready_i), .mem_aw_addr_o  (mem_aw_addr_o),
    .mem_w_valid_o  (mem_w_valid_o),  .mem_w_ready_i  (mem_w_ready_i),
    .mem_b_valid_i  (mem_b_valid_i),  .mem_b_ready_o  (mem_b_ready_o),
    .lookup_index_o (lookup_index),   .lookup_tag_o   (lookup_tag),
    .hit_i          (hit),            .hit_way_i      (hit_way),
    .victim_way_i   (victim_way),     .victim_dirty_i (victim_dirty),
    .victim_tag_i   (victim_tag),     .upd_en_o       (upd_en),
    .upd_way_o      (upd_way),        .upd_index_o    (upd_index),
    .upd_tag_o      (upd_tag),        .upd_valid_o    (upd_valid),
    .set_dirty_o    (set_dirty),      .ram_rd_o       (ram_rd),
    .ram_wr_o       (ram_wr),         .ram_way_o      (ram_way),
    .ram_index_o    (ram_index),      .fill_o         (fill),
    .beat_o         (beat),           .word_sel_o     (word_sel)
  );

  dcache_tag_store i_tags (
    .clk            (clk),            .rst            (rst),
    .lookup_index_i (lookup_index),   .lookup_tag_i   (lookup_tag),
    .hit_o          (hit),            .hit_way_o      (hit_way),
    .victim_way_o   (victim_way),     .victim_dirty_o (victim_dirty),
    .victim_tag_o   (victim_tag),     .upd_en_i       (upd_en),
    .upd_way_i      (upd_way),        .upd_index_i    (upd_index),
    .upd_tag_i      (upd_tag),        .upd_valid_i    (upd_valid),
    .set_dirty_i    (set_dirty)
  );

  dcache_data_path i_data (
    .clk            (clk),            .rd_en_i        (ram_rd),
    .wr_en_i        (ram_wr),         .way_i          (ram_way),
    .index_i        (ram_index),      .fill_i         (fill),
    .beat_i         (beat),           .word_sel_i     (word_sel),
    .w_strb_i       (w_strb_i),       .w_data_i       (w_data_i),
    .mem_r_data_i   (mem_r_data_i),   .rd_word_o      (r_data_o),
    .wb_word_o      (mem_w_data_o)
  );

endmodule

// ==== verilog/dcache_way_ram.sv ====
// line storage for one cache way
// bit-masked write, registered read port that holds its value
`timescale 1ns/10ps
`include "dcache_consts.svh"

module dcache_way_ram (
  input  logic               clk,
  input  logic               rd_en_i,
  input  logic               wr_en_i,
  input  dcache_pkg::index_t index_i,
  input  dcache_pkg::line_t  wmask_i,
  input  dcache_pkg::line_t  wdata_i,
  output dcache_pkg::line_t  rdata_o
);

  dcache_pkg::line_t mem_q [`DC_SETS];

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem_q[index_i] <= (mem_q[index_i] & ~wmask_i) | (wdata_i & wmask_i);
    end
    // output only moves on a read strobe
    if (rd_en_i) begin
      rdata_o <= mem_q[index_i];
    end
  end

endmodule
